// File: source/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_inst_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } rv_inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } rv_inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_inst_j_t;

    // One instruction word, six ways to read it.
    typedef union packed {
        rv_inst_r_t r;
        rv_inst_i_t i;
        rv_inst_s_t s;
        rv_inst_b_t b;
        rv_inst_u_t u;
        rv_inst_j_t j;
    } rv_inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic       { OP1_REG1, OP1_PC } op1_src_e;
    typedef enum logic [1:0] { OP2_REG2, OP2_IMM_I, OP2_IMM_J } op2_src_e;
    typedef enum logic       { RES_ALU, RES_PC_P4 } res_src_e;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm_i;        // Also carries U-type immediates.
        logic [31:0] imm_j;        // Also carries B-type immediates.
        alu_op_e     alu_op;
        op1_src_e    op1_src;
        op2_src_e    op2_src;
        res_src_e    res_src;
        logic        reg_write;
        logic        inst_jal;
        logic        inst_jalr;
        logic        inst_branch;
        logic [2:0]  funct3;
        logic [31:0] pc;
        logic [31:0] pc_p4;
    } decode_bus_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] reg_data2;
        alu_op_e     alu_op;
        res_src_e    res_src;
        logic        reg_write;
        logic [4:0]  rd;
        logic        inst_jump;
        logic        inst_branch;
        logic [2:0]  funct3;
        logic [31:0] pc_p4;
        logic [31:0] pc_target;
    } exec_bus_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_bus_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: source/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
    import rv_exec_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_reset_n,
    input  wire              i_inst_valid,
    input  wire rv_inst_u    i_inst,
    input  wire [31:0]       i_pc,
    output decode_bus_t      o_bus
);

    rv_inst_u    inst_q;
    logic [31:0] pc_q;
    logic        valid_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            valid_q <= 1'b0;
        else
            valid_q <= i_inst_valid;
    end

    // Word and PC hold until the next strobe.
    always_ff @(posedge i_clk)
    begin
        if (i_inst_valid)
        begin
            inst_q <= i_inst;
            pc_q   <= i_pc;
        end
    end

    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt,
                                         input logic allow_sub);
        alu_op_e op;
        case (funct3)
            3'b000:  op = (alt && allow_sub) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        o_bus.valid       = valid_q;
        o_bus.rs1         = inst_q.r.rs1;
        o_bus.rs2         = inst_q.r.rs2;
        o_bus.rd          = inst_q.r.rd;
        o_bus.funct3      = inst_q.r.funct3;
        o_bus.pc          = pc_q;
        o_bus.pc_p4       = pc_q + 32'd4;
        o_bus.imm_i       = {{20{inst_q.i.imm_11_0[11]}}, inst_q.i.imm_11_0};
        o_bus.imm_j       = {{19{inst_q.b.imm_12}}, inst_q.b.imm_12, inst_q.b.imm_11,
                             inst_q.b.imm_10_5, inst_q.b.imm_4_1, 1'b0};
        o_bus.alu_op      = ALU_ADD;
        o_bus.op1_src     = OP1_REG1;
        o_bus.op2_src     = OP2_REG2;
        o_bus.res_src     = RES_ALU;
        o_bus.reg_write   = 1'b0;
        o_bus.inst_jal    = 1'b0;
        o_bus.inst_jalr   = 1'b0;
        o_bus.inst_branch = 1'b0;

        if (valid_q)
        begin
            case (inst_q.r.opcode)
                OPC_OP:
                begin
                    o_bus.alu_op    = arith_op(inst_q.r.funct3, inst_q.r.funct7[5], 1'b1);
                    o_bus.reg_write = 1'b1;
                end
                OPC_OP_IMM:
                begin
                    // Bit 10 of the immediate picks SRAI.
                    o_bus.alu_op    = arith_op(inst_q.i.funct3, inst_q.i.imm_11_0[10], 1'b0);
                    o_bus.op2_src   = OP2_IMM_I;
                    o_bus.reg_write = 1'b1;
                end
                OPC_LUI:
                begin
                    o_bus.imm_i     = {inst_q.u.imm_31_12, 12'b0};
                    o_bus.alu_op    = ALU_PASS_B;
                    o_bus.op2_src   = OP2_IMM_I;
                    o_bus.reg_write = 1'b1;
                end
                OPC_AUIPC:
                begin
                    o_bus.imm_i     = {inst_q.u.imm_31_12, 12'b0};
                    o_bus.op1_src   = OP1_PC;
                    o_bus.op2_src   = OP2_IMM_I;
                    o_bus.reg_write = 1'b1;
                end
                OPC_JAL:
                begin
                    o_bus.imm_j     = {{11{inst_q.j.imm_20}}, inst_q.j.imm_20,
                                       inst_q.j.imm_19_12, inst_q.j.imm_11,
                                       inst_q.j.imm_10_1, 1'b0};
                    o_bus.res_src   = RES_PC_P4;
                    o_bus.reg_write = 1'b1;
                    o_bus.inst_jal  = 1'b1;
                end
                OPC_JALR:
                begin
                    o_bus.res_src   = RES_PC_P4;
                    o_bus.reg_write = 1'b1;
                    o_bus.inst_jalr = 1'b1;
                end
                OPC_BRANCH:
                    o_bus.inst_branch = 1'b1;   // Target comes from imm_j.
                default:
                    o_bus.reg_write = 1'b0;     // Unsupported, no side effects.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
    import rv_exec_pkg::*;
(
    input  wire             i_clk,
    input  wire [4:0]       i_rs1,
    input  wire [4:0]       i_rs2,
    input  wire wb_bus_t    i_wb,
    output logic [31:0]     o_rs1_data,
    output logic [31:0]     o_rs2_data
);

    logic [31:0] regs [1:31];    // x0 has no storage.

    always_ff @(posedge i_clk)
    begin
        if (i_wb.valid && (i_wb.rd != 5'd0))
            regs[i_wb.rd] <= i_wb.data;
    end

    always_comb
    begin
        o_rs1_data = (i_rs1 == 5'd0) ? 32'd0 : regs[i_rs1];
        o_rs2_data = (i_rs2 == 5'd0) ? 32'd0 : regs[i_rs2];
    end

endmodule

`default_nettype wire

// File: source/rv_operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_operand_stage
    import rv_exec_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_reset_n,
    input  wire decode_bus_t    i_bus,
    input  wire [31:0]          i_reg1_data,
    input  wire [31:0]          i_reg2_data,
    output exec_bus_t           o_bus
);

    decode_bus_t bus_q;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] pc_target;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            bus_q.valid       <= 1'b0;
            bus_q.reg_write   <= 1'b0;
            bus_q.inst_jal    <= 1'b0;
            bus_q.inst_jalr   <= 1'b0;
            bus_q.inst_branch <= 1'b0;
        end
        else
            bus_q <= i_bus;
    end

    // Register data arrives straight from the register file.
    always_comb
    begin
        case (bus_q.op1_src)
            OP1_PC:  op1 = bus_q.pc;
            default: op1 = i_reg1_data;
        endcase

        case (bus_q.op2_src)
            OP2_IMM_I: op2 = bus_q.imm_i;
            OP2_IMM_J: op2 = bus_q.imm_j;
            default:   op2 = i_reg2_data;
        endcase

        if (bus_q.inst_jalr)
            pc_target = (i_reg1_data + bus_q.imm_i) & ~32'd1;
        else
            pc_target = bus_q.pc + bus_q.imm_j;    // JAL and branches.
    end

    always_comb
    begin
        o_bus.valid       = bus_q.valid;
        o_bus.op1         = op1;
        o_bus.op2         = op2;
        o_bus.reg_data2   = i_reg2_data;
        o_bus.alu_op      = bus_q.alu_op;
        o_bus.res_src     = bus_q.res_src;
        o_bus.reg_write   = bus_q.reg_write;
        o_bus.rd          = bus_q.rd;
        o_bus.inst_jump   = bus_q.inst_jal | bus_q.inst_jalr;
        o_bus.inst_branch = bus_q.inst_branch;
        o_bus.funct3      = bus_q.funct3;
        o_bus.pc_p4       = bus_q.pc_p4;
        o_bus.pc_target   = pc_target;
    end

endmodule

`default_nettype wire

// File: source/rv_alu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_stage
    import rv_exec_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_reset_n,
    input  wire exec_bus_t      i_bus,
    output wb_bus_t             o_wb,
    output redirect_t           o_redirect
);

    logic [31:0] alu_result;
    logic [4:0]  shamt;
    logic        taken;

    assign shamt = i_bus.op2[4:0];

    always_comb
    begin
        case (i_bus.alu_op)
            ALU_ADD:    alu_result = i_bus.op1 + i_bus.op2;
            ALU_SUB:    alu_result = i_bus.op1 - i_bus.op2;
            ALU_SLL:    alu_result = i_bus.op1 << shamt;
            ALU_SLT:    alu_result = {31'd0, $signed(i_bus.op1) < $signed(i_bus.op2)};
            ALU_SLTU:   alu_result = {31'd0, i_bus.op1 < i_bus.op2};
            ALU_XOR:    alu_result = i_bus.op1 ^ i_bus.op2;
            ALU_SRL:    alu_result = i_bus.op1 >> shamt;
            ALU_SRA:    alu_result = $unsigned($signed(i_bus.op1) >>> shamt);
            ALU_OR:     alu_result = i_bus.op1 | i_bus.op2;
            ALU_AND:    alu_result = i_bus.op1 & i_bus.op2;
            default:    alu_result = i_bus.op2;    // Pass B, for LUI.
        endcase
    end

    // Compares rs1 with rs2; op2 may hold an immediate.
    always_comb
    begin
        case (i_bus.funct3)
            3'b000:  taken = (i_bus.op1 == i_bus.reg_data2);
            3'b001:  taken = (i_bus.op1 != i_bus.reg_data2);
            3'b100:  taken = ($signed(i_bus.op1) < $signed(i_bus.reg_data2));
            3'b101:  taken = ($signed(i_bus.op1) >= $signed(i_bus.reg_data2));
            3'b110:  taken = (i_bus.op1 < i_bus.reg_data2);
            3'b111:  taken = (i_bus.op1 >= i_bus.reg_data2);
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_wb.valid       <= 1'b0;
            o_redirect.valid <= 1'b0;
        end
        else
        begin
            o_wb.valid <= i_bus.valid & i_bus.reg_write;
            o_wb.rd    <= i_bus.rd;
            if (i_bus.res_src == RES_PC_P4)
                o_wb.data <= i_bus.pc_p4;
            else
                o_wb.data <= alu_result;

            o_redirect.valid  <= i_bus.valid & (i_bus.inst_jump | (i_bus.inst_branch & taken));
            o_redirect.target <= i_bus.pc_target;
        end
    end

endmodule

`default_nettype wire

// File: source/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top
    import rv_exec_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_reset_n,
    input  wire              i_inst_valid,
    input  wire rv_inst_u    i_inst,
    input  wire [31:0]       i_pc,
    output wb_bus_t          o_wb,
    output redirect_t        o_redirect
);

    decode_bus_t dec_bus;
    exec_bus_t   exec_bus;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    rv_decoder u_decoder (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .o_bus        (dec_bus)
    );

    // Written back from the ALU stage output.
    rv_regfile u_regfile (
        .i_clk        (i_clk),
        .i_rs1        (dec_bus.rs1),
        .i_rs2        (dec_bus.rs2),
        .i_wb         (o_wb),
        .o_rs1_data   (rs1_data),
        .o_rs2_data   (rs2_data)
    );

    rv_operand_stage u_operand_stage (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_bus        (dec_bus),
        .i_reg1_data  (rs1_data),
        .i_reg2_data  (rs2_data),
        .o_bus        (exec_bus)
    );

    rv_alu_stage u_alu_stage (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_bus        (exec_bus),
        .o_wb         (o_wb),
        .o_redirect   (o_redirect)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset_n
);

    initial
    begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;    // 4 ns period.
    end

    // Reset is held over two rising edges, released on a falling edge.
    initial
    begin
        o_reset_n = 1'b0;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec
    import rv_exec_pkg::*;
();

    typedef struct packed {
        rv_inst_u    inst;
        logic [31:0] pc;
        wb_bus_t     exp_wb;
        redirect_t   exp_redirect;
    } test_row_t;

    logic        clk;
    logic        reset_n;
    logic        inst_valid;
    rv_inst_u    inst;
    logic [31:0] pc;
    wb_bus_t     o_wb;
    redirect_t   o_redirect;

    test_row_t   rows[$];
    string       row_names[$];
    logic        table_ready = 1'b0;
    int          cycle_count = 0;
    int          cycle_limit;

    tb_clock_gen u_clock_gen (
        .o_clk        (clk),
        .o_reset_n    (reset_n)
    );

    rv_exec_top i_rv_exec_top (
        .i_clk        (clk),
        .i_reset_n    (reset_n),
        .i_inst_valid (inst_valid),
        .i_inst       (inst),
        .i_pc         (pc),
        .o_wb         (o_wb),
        .o_redirect   (o_redirect)
    );

    function automatic logic [31:0] encode_r_type(input logic [6:0] funct7,
                                                  input logic [4:0] rs2, input logic [4:0] rs1,
                                                  input logic [2:0] funct3, input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] encode_i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                                  input logic [2:0] funct3, input logic [4:0] rd,
                                                  input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_u_type(input logic [19:0] imm, input logic [4:0] rd,
                                                  input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_jal(input logic [20:0] offset, input logic [4:0] rd);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] encode_branch(input logic [12:0] offset,
                                                  input logic [4:0] rs2, input logic [4:0] rs1,
                                                  input logic [2:0] funct3);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], OPC_BRANCH};
    endfunction

    function automatic wb_bus_t wb_write(input logic [4:0] rd, input logic [31:0] data);
        wb_bus_t wb;
        wb.valid = 1'b1;
        wb.rd    = rd;
        wb.data  = data;
        return wb;
    endfunction

    function automatic wb_bus_t wb_none();
        return '0;
    endfunction

    function automatic redirect_t redirect_to(input logic [31:0] target);
        redirect_t rd;
        rd.valid  = 1'b1;
        rd.target = target;
        return rd;
    endfunction

    function automatic redirect_t redirect_none();
        return '0;
    endfunction

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    // Payload is only compared when a valid record is expected.
    task automatic check_wb(input string name, input wb_bus_t exp, input wb_bus_t act);
        if ((exp.valid && (act !== exp)) || (!exp.valid && (act.valid !== 1'b0)))
        begin
            $write("error: %s o_wb expected valid=%0b rd=%0d data=0x%08h", name, exp.valid,
                   exp.rd, exp.data);
            $display(", actual valid=%0b rd=%0d data=0x%08h", act.valid, act.rd, act.data);
            stop_with_failure();
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t exp, input redirect_t act);
        if ((exp.valid && (act !== exp)) || (!exp.valid && (act.valid !== 1'b0)))
        begin
            $write("error: %s o_redirect expected valid=%0b target=0x%08h", name, exp.valid,
                   exp.target);
            $display(", actual valid=%0b target=0x%08h", act.valid, act.target);
            stop_with_failure();
        end
    endtask

    task automatic check_quiet(input string name);
        check_wb(name, wb_none(), o_wb);
        check_redirect(name, redirect_none(), o_redirect);
    endtask

    task automatic add_row(input string name, input logic [31:0] word, input logic [31:0] row_pc,
                           input wb_bus_t exp_wb, input redirect_t exp_redirect);
        test_row_t row;
        row.inst         = rv_inst_u'(word);
        row.pc           = row_pc;
        row.exp_wb       = exp_wb;
        row.exp_redirect = exp_redirect;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    // x1 = 5, x2 = -3, x3 = 0x80000000, x4 = 0x12345100 once the first rows are done.
    task automatic build_table();
        add_row("addi_x1", encode_i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 32'h0000_0000,
                wb_write(5'd1, 32'd5), redirect_none());
        add_row("addi_x2_neg", encode_i_type(12'hFFD, 5'd0, 3'b000, 5'd2, OPC_OP_IMM),
                32'h0000_0004, wb_write(5'd2, 32'hFFFF_FFFD), redirect_none());
        add_row("lui_x3", encode_u_type(20'h80000, 5'd3, OPC_LUI), 32'h0000_0008,
                wb_write(5'd3, 32'h8000_0000), redirect_none());
        add_row("auipc_x4", encode_u_type(20'h12345, 5'd4, OPC_AUIPC), 32'h0000_0100,
                wb_write(5'd4, 32'h1234_5100), redirect_none());
        add_row("addi_x0", encode_i_type(12'd7, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 32'h0000_0104,
                wb_write(5'd0, 32'd12), redirect_none());
        add_row("add_x0_zero", encode_r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd5), 32'h0000_0108,
                wb_write(5'd5, 32'd5), redirect_none());

        add_row("add", encode_r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'd2), redirect_none());
        add_row("sub", encode_r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'd8), redirect_none());
        add_row("sll", encode_r_type(7'h00, 5'd1, 5'd2, 3'b001, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'hFFFF_FFA0), redirect_none());
        add_row("slt_neg_pos", encode_r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'd1), redirect_none());
        add_row("slt_pos_neg", encode_r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'd0), redirect_none());
        add_row("sltu_big_small", encode_r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'd0), redirect_none());
        add_row("sltu_small_big", encode_r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'd1), redirect_none());
        add_row("xor", encode_r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'hFFFF_FFF8), redirect_none());
        add_row("srl", encode_r_type(7'h00, 5'd1, 5'd3, 3'b101, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'h0400_0000), redirect_none());
        add_row("sra", encode_r_type(7'h20, 5'd1, 5'd3, 3'b101, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'hFC00_0000), redirect_none());
        add_row("or", encode_r_type(7'h00, 5'd3, 5'd1, 3'b110, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'h8000_0005), redirect_none());
        add_row("and", encode_r_type(7'h00, 5'd1, 5'd2, 3'b111, 5'd7), 32'h0000_0200,
                wb_write(5'd7, 32'd5), redirect_none());

        add_row("jal_fwd", encode_jal(21'h000100, 5'd8), 32'h0000_2000,
                wb_write(5'd8, 32'h0000_2004), redirect_to(32'h0000_2100));
        add_row("jal_back", encode_jal(21'h1FFFF0, 5'd8), 32'h0000_2100,
                wb_write(5'd8, 32'h0000_2104), redirect_to(32'h0000_20F0));
        add_row("jalr_odd", encode_i_type(12'h023, 5'd4, 3'b000, 5'd9, OPC_JALR), 32'h0000_3000,
                wb_write(5'd9, 32'h0000_3004), redirect_to(32'h1234_5122));

        add_row("beq_taken", encode_branch(13'h0040, 5'd5, 5'd1, 3'b000), 32'h0000_4000,
                wb_none(), redirect_to(32'h0000_4040));
        add_row("beq_not", encode_branch(13'h0040, 5'd2, 5'd1, 3'b000), 32'h0000_4000,
                wb_none(), redirect_none());
        add_row("bne_taken", encode_branch(13'h1FE0, 5'd2, 5'd1, 3'b001), 32'h0000_4000,
                wb_none(), redirect_to(32'h0000_3FE0));
        add_row("bne_not", encode_branch(13'h1FE0, 5'd5, 5'd1, 3'b001), 32'h0000_4000,
                wb_none(), redirect_none());
        add_row("blt_taken", encode_branch(13'h0800, 5'd1, 5'd2, 3'b100), 32'h0000_4000,
                wb_none(), redirect_to(32'h0000_4800));
        add_row("blt_not", encode_branch(13'h0800, 5'd2, 5'd1, 3'b100), 32'h0000_4000,
                wb_none(), redirect_none());
        add_row("bge_taken", encode_branch(13'h1000, 5'd2, 5'd1, 3'b101), 32'h0000_4000,
                wb_none(), redirect_to(32'h0000_3000));
        add_row("bge_not", encode_branch(13'h1000, 5'd1, 5'd2, 3'b101), 32'h0000_4000,
                wb_none(), redirect_none());
        add_row("bltu_taken", encode_branch(13'h07FE, 5'd2, 5'd1, 3'b110), 32'h0000_4000,
                wb_none(), redirect_to(32'h0000_47FE));
        add_row("bltu_not", encode_branch(13'h07FE, 5'd1, 5'd2, 3'b110), 32'h0000_4000,
                wb_none(), redirect_none());
        add_row("bgeu_taken", encode_branch(13'h0010, 5'd1, 5'd2, 3'b111), 32'h0000_4000,
                wb_none(), redirect_to(32'h0000_4010));
        add_row("bgeu_not", encode_branch(13'h0010, 5'd2, 5'd1, 3'b111), 32'h0000_4000,
                wb_none(), redirect_none());

        // Load opcode is outside the slice.
        add_row("load_unsupported", encode_i_type(12'd0, 5'd1, 3'b010, 5'd10, 7'b0000011),
                32'h0000_5000, wb_none(), redirect_none());
    endtask

    // Records are due after the third rising edge that follows the strobe.
    task automatic run_row(input int k);
        @(negedge clk);
        check_quiet({row_names[k], " before strobe"});
        inst_valid = 1'b1;
        inst       = rows[k].inst;
        pc         = rows[k].pc;
        @(negedge clk);
        inst_valid = 1'b0;
        check_quiet({row_names[k], " cycle 1"});
        @(negedge clk);
        check_quiet({row_names[k], " cycle 2"});
        @(negedge clk);
        check_wb(row_names[k], rows[k].exp_wb, o_wb);
        check_redirect(row_names[k], rows[k].exp_redirect, o_redirect);
    endtask

    initial
    begin
        inst_valid = 1'b0;
        inst       = '0;
        pc         = 32'd0;
        build_table();
        table_ready = 1'b1;
        wait (reset_n == 1'b1);
        repeat (6)
        begin
            @(negedge clk);
            check_quiet("idle after reset");
        end
        for (int k = 0; k < rows.size(); k++)
            run_row(k);
        @(negedge clk);
        check_quiet("final idle");
        $display("Test OK");
        $finish;
    end

    initial
    begin
        wait (table_ready == 1'b1);
        cycle_limit = 4 * rows.size() + 20;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the test sequence did not finish within %0d cycles", cycle_limit);
        stop_with_failure();
    end

endmodule

`default_nettype wire

// File: compile.f
source/rv_exec_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_operand_stage.sv
source/rv_alu_stage.sv
source/rv_exec_top.sv
dv/tb_clock_gen.sv
dv/tb_rv_exec.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_rv_exec -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_exec > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "run.sh: simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: pass message not found in $LOG"
    exit 1
fi
